//--- sim.f
source/sha256_pkg.sv
source/sha256_k_rom.sv
source/sha256_w_sched.sv
source/sha256_core.sv
source/sha256_regs.sv
source/sha256.sv
tests/tb_sha256.sv

//--- Bender.yml
package:
  name: sha256

sources:
  - source/sha256_pkg.sv
  - source/sha256_k_rom.sv
  - source/sha256_w_sched.sv
  - source/sha256_core.sv
  - source/sha256_regs.sv
  - source/sha256.sv
  - target: test
    files:
      - tests/tb_sha256.sv

//--- tests/tb_sha256.sv
// --------------------------------------
// SHA-256 accelerator testbench
// Known-answer hashes in both modes,
// zeroize, interrupts and the error path
// --------------------------------------
`default_nettype none

module tb_sha256;
  timeunit 1ns;
  timeprecision 1ps;

  // Upper bound for every polling loop
  localparam int poll_limit = 200;

  // FIPS 180-4 reference digests, word 0 first
  localparam logic [0:7][31:0] abc_256 = {
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };
  // SHA-224 keeps seven words, the eighth reads zero
  localparam logic [0:7][31:0] abc_224 = {
    32'h23097d22, 32'h3405d822, 32'h8642a477, 32'hbda255b3,
    32'h2aadbce4, 32'hbda0b3f7, 32'he36c9da7, 32'h00000000
  };
  localparam logic [0:7][31:0] two_blk_256 = {
    32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
    32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
  };

  logic                             clk;
  logic                             reset_n;
  logic                             cs;
  logic                             we;
  logic [sha256_pkg::addr_width-1:0] address;
  logic [sha256_pkg::data_width-1:0] write_data;
  logic [sha256_pkg::data_width-1:0] read_data;
  logic                             err;
  logic                             notif_intr;
  logic                             error_intr;

  // Block image written by write_block
  logic [0:15][31:0] blk;
  // err as seen during the latest host access
  logic              last_err;
  int                checks_failed;
  int                tests_run;
  int                tests_failed;
  int                mark;

  sha256 i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .cs         (cs),
    .we         (we),
    .address    (address),
    .write_data (write_data),
    .read_data  (read_data),
    .err        (err),
    .notif_intr (notif_intr),
    .error_intr (error_intr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // --------------------------------------
  // Bus level checks
  // --------------------------------------
  // Deselected bus returns zero and no error
  a_idle_bus: assert property (@(posedge clk) disable iff (!reset_n)
    !cs |-> (read_data == '0 && !err))
    else begin
      $display("Bus drove read data or err while cs was low");
      checks_failed++;
    end

  // Outputs never go unknown once out of reset
  a_known_out: assert property (@(posedge clk) disable iff (!reset_n)
    !$isunknown({err, notif_intr, error_intr, read_data}))
    else begin
      $display("DUT output went unknown");
      checks_failed++;
    end

  // --------------------------------------
  // Host access and check helpers
  // --------------------------------------
  // One access per call, cs dropped on the following falling edge
  task automatic host_write(input logic [7:0] a, input logic [31:0] d);
    @(negedge clk);
    cs         = 1'b1;
    we         = 1'b1;
    address    = a;
    write_data = d;
    #1;
    last_err = err;
    @(negedge clk);
    cs = 1'b0;
    we = 1'b0;
  endtask

  task automatic host_read(input logic [7:0] a, output logic [31:0] d);
    @(negedge clk);
    cs      = 1'b1;
    we      = 1'b0;
    address = a;
    #1;
    d        = read_data;
    last_err = err;
    @(negedge clk);
    cs = 1'b0;
  endtask

  task automatic check_value(input string test, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
      else begin
        $display("[FAIL] %s expected %08h actual %08h", test, exp, act);
        checks_failed++;
      end
  endtask

  // CTRL word from its fields
  function automatic logic [31:0] ctrl_word(input bit init, input bit next,
                                            input bit mode, input bit zero);
    logic [31:0] v;
    v = '0;
    v[sha256_pkg::ctrl_init_bit]    = init;
    v[sha256_pkg::ctrl_next_bit]    = next;
    v[sha256_pkg::ctrl_mode_bit]    = mode;
    v[sha256_pkg::ctrl_zeroize_bit] = zero;
    return v;
  endfunction

  task automatic write_block();
    for (int i = 0; i < sha256_pkg::block_words; i++) begin
      host_write(sha256_pkg::addr_block_base + 8'(i), blk[i]);
    end
  endtask

  task automatic check_digest(input string test, input logic [0:7][31:0] exp);
    logic [31:0] d;
    for (int i = 0; i < sha256_pkg::digest_words; i++) begin
      host_read(sha256_pkg::addr_digest_base + 8'(i), d);
      check_value(test, exp[i], d);
    end
  endtask

  // Poll STATUS until ready and valid are both set
  task automatic wait_done(input string test);
    logic [31:0] status;
    int          polls;
    bit          done;
    polls = 0;
    done  = 1'b0;
    while (!done && polls < poll_limit) begin
      host_read(sha256_pkg::addr_status, status);
      done = status[sha256_pkg::status_ready_bit] && status[sha256_pkg::status_valid_bit];
      polls++;
    end
    if (!done) begin
      $display("%s: core did not report a valid digest in time", test);
      checks_failed++;
    end
  endtask

  // Wait for an interrupt line to reach a level
  task automatic wait_intr(input bit error_line, input logic level, input string test);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = error_line ? error_intr : notif_intr;
    while (seen !== level && cycles < poll_limit) begin
      @(negedge clk);
      seen = error_line ? error_intr : notif_intr;
      cycles++;
    end
    assert (seen === level)
      else begin
        $display("%s: %s interrupt did not reach %0d in time", test,
                 error_line ? "error" : "notif", level);
        checks_failed++;
      end
  endtask

  task automatic finish_test(input string test);
    tests_run++;
    if (checks_failed != mark) begin
      tests_failed++;
      $display("%s: %0d failed checks", test, checks_failed - mark);
    end else begin
      $display("%s: ok", test);
    end
    mark = checks_failed;
  endtask

  // --------------------------------------
  // Test sequence
  // --------------------------------------
  initial begin
    logic [31:0] data;
    void'($urandom(32'h11a2));
    reset_n       = 1'b0;
    cs            = 1'b0;
    we            = 1'b0;
    address       = '0;
    write_data    = '0;
    blk           = '0;
    last_err      = 1'b0;
    checks_failed = 0;
    tests_run     = 0;
    tests_failed  = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
    mark    = checks_failed;

    // Identity and reset state
    host_read(sha256_pkg::addr_status, data);
    check_value("reset", 32'd1 << sha256_pkg::status_ready_bit, data);
    host_read(sha256_pkg::addr_name0, data);
    check_value("reset", sha256_pkg::name0_value, data);
    host_read(sha256_pkg::addr_name1, data);
    check_value("reset", sha256_pkg::name1_value, data);
    host_read(sha256_pkg::addr_version, data);
    check_value("reset", sha256_pkg::version_value, data);
    check_value("reset", 32'd0, 32'(last_err));
    host_read(sha256_pkg::addr_intr_sts, data);
    check_value("reset", 32'd0, data);
    finish_test("reset");

    // Padded "abc", a single block
    blk     = '0;
    blk[0]  = 32'h6162_6380;
    blk[15] = 32'h0000_0018;
    write_block();
    host_write(sha256_pkg::addr_intr_en, 32'd1 << sha256_pkg::intr_notif_bit);
    host_write(sha256_pkg::addr_ctrl, ctrl_word(1, 0, 1, 0));
    wait_done("sha256_abc");
    check_digest("sha256_abc", abc_256);
    wait_intr(1'b0, 1'b1, "sha256_abc");
    host_write(sha256_pkg::addr_intr_sts, 32'd1 << sha256_pkg::intr_notif_bit);
    wait_intr(1'b0, 1'b0, "sha256_abc");
    finish_test("sha256_abc");

    // Same block with the SHA-224 IV
    write_block();
    host_write(sha256_pkg::addr_ctrl, ctrl_word(1, 0, 0, 0));
    wait_done("sha224_abc");
    check_digest("sha224_abc", abc_224);
    finish_test("sha224_abc");

    // 448-bit message, word i starts at letter 'a'+i
    blk = '0;
    for (int i = 0; i < 14; i++) begin
      blk[i] = {8'(8'h61 + i), 8'(8'h62 + i), 8'(8'h63 + i), 8'(8'h64 + i)};
    end
    blk[14] = 32'h8000_0000;
    write_block();
    host_write(sha256_pkg::addr_ctrl, ctrl_word(1, 0, 1, 0));
    wait_done("sha256_two_block");
    // Second block holds only the bit length
    blk     = '0;
    blk[15] = 32'h0000_01c0;
    write_block();
    host_write(sha256_pkg::addr_ctrl, ctrl_word(0, 1, 1, 0));
    wait_done("sha256_two_block");
    check_digest("sha256_two_block", two_blk_256);
    finish_test("sha256_two_block");

    // Random block, hash it, then wipe everything
    for (int i = 0; i < 16; i++) begin
      blk[i] = $urandom;
    end
    write_block();
    host_write(sha256_pkg::addr_ctrl, ctrl_word(1, 0, 1, 0));
    wait_done("zeroize");
    host_write(sha256_pkg::addr_ctrl, ctrl_word(0, 0, 1, 1));
    for (int i = 0; i < sha256_pkg::block_words; i++) begin
      host_read(sha256_pkg::addr_block_base + 8'(i), data);
      check_value("zeroize", 32'd0, data);
    end
    check_digest("zeroize", '0);
    host_read(sha256_pkg::addr_status, data);
    check_value("zeroize", 32'd1 << sha256_pkg::status_ready_bit, data);
    finish_test("zeroize");

    // Unmapped read and read-only write
    host_write(sha256_pkg::addr_intr_sts, 32'h3);
    host_write(sha256_pkg::addr_intr_en, 32'd1 << sha256_pkg::intr_error_bit);
    host_read(8'h30, data);
    check_value("error_path", 32'd1, 32'(last_err));
    check_value("error_path", 32'd0, data);
    wait_intr(1'b1, 1'b1, "error_path");
    // Cleared first, so only the read-only write can set it again
    host_write(sha256_pkg::addr_intr_sts, 32'd1 << sha256_pkg::intr_error_bit);
    host_write(sha256_pkg::addr_status, $urandom);
    check_value("error_path", 32'd1, 32'(last_err));
    host_read(sha256_pkg::addr_intr_sts, data);
    check_value("error_path", 32'd1, 32'(data[sha256_pkg::intr_error_bit]));
    // Enable gates the line, status stays set
    host_write(sha256_pkg::addr_intr_en, 32'd0);
    wait_intr(1'b1, 1'b0, "error_path");
    host_write(sha256_pkg::addr_intr_en, 32'd1 << sha256_pkg::intr_error_bit);
    wait_intr(1'b1, 1'b1, "error_path");
    host_write(sha256_pkg::addr_intr_sts, 32'd1 << sha256_pkg::intr_error_bit);
    wait_intr(1'b1, 1'b0, "error_path");
    finish_test("error_path");

    $display("Tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, checks_failed);
    if (checks_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/sha256.sv
// --------------------------------------
// SHA-256 accelerator top level
// Host register file driving the core
// --------------------------------------
`default_nettype none

module sha256 (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             cs,
  input  logic                             we,
  input  logic [sha256_pkg::addr_width-1:0] address,
  input  logic [sha256_pkg::data_width-1:0] write_data,
  output logic [sha256_pkg::data_width-1:0] read_data,
  output logic                             err,
  output logic                             notif_intr,
  output logic                             error_intr
);

  // Register file to core
  logic         init_cmd;
  logic         next_cmd;
  logic         mode;
  logic         zeroize;
  logic [511:0] block_msg;
  // Core back to register file
  logic         core_ready;
  logic [255:0] core_digest;
  logic         core_digest_valid;

  sha256_regs i_regs (
    .clk               (clk),
    .reset_n           (reset_n),
    .cs                (cs),
    .we                (we),
    .address           (address),
    .write_data        (write_data),
    .read_data         (read_data),
    .err               (err),
    .init_cmd          (init_cmd),
    .next_cmd          (next_cmd),
    .mode              (mode),
    .zeroize           (zeroize),
    .block_msg         (block_msg),
    .core_ready        (core_ready),
    .core_digest       (core_digest),
    .core_digest_valid (core_digest_valid),
    .notif_intr        (notif_intr),
    .error_intr        (error_intr)
  );

  sha256_core i_core (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .mode         (mode),
    .block_msg    (block_msg),
    .ready        (core_ready),
    .digest       (core_digest),
    .digest_valid (core_digest_valid)
  );

endmodule

`default_nettype wire

//--- source/sha256_regs.sv
// --------------------------------------
// SHA-256 host register file
// Address decode, control pulses, block
// and digest storage, status, interrupts
// --------------------------------------
`default_nettype none

module sha256_regs (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             cs,
  input  logic                             we,
  input  logic [sha256_pkg::addr_width-1:0] address,
  input  logic [sha256_pkg::data_width-1:0] write_data,
  output logic [sha256_pkg::data_width-1:0] read_data,
  output logic                             err,
  output logic                             init_cmd,
  output logic                             next_cmd,
  output logic                             mode,
  output logic                             zeroize,
  output logic [511:0]                     block_msg,
  input  logic                             core_ready,
  input  logic [255:0]                     core_digest,
  input  logic                             core_digest_valid,
  output logic                             notif_intr,
  output logic                             error_intr
);

  // Word 0 of each store is the most significant word
  logic [0:sha256_pkg::block_words-1][31:0]  block_mem;
  logic [0:sha256_pkg::digest_words-1][31:0] digest_reg;
  logic [1:0]  intr_sts;
  logic [1:0]  intr_en;
  logic        valid_d;
  logic        digest_rise;
  logic [31:0] rdata;
  logic        mapped;
  logic        read_only;
  logic        wr;
  logic        blk_hit;
  logic        dig_hit;

  assign wr          = cs && we;
  assign blk_hit     = (address[7:4] == sha256_pkg::addr_block_base[7:4]);
  assign dig_hit     = (address[7:3] == sha256_pkg::addr_digest_base[7:3]);
  assign digest_rise = core_digest_valid && !valid_d;
  assign block_msg   = block_mem;

  // --------------------------------------
  // Read mux and access checking
  // --------------------------------------
  always_comb begin
    rdata     = '0;
    mapped    = 1'b1;
    read_only = 1'b0;
    if (blk_hit) begin
      rdata = block_mem[address[3:0]];
    end else if (dig_hit) begin
      read_only = 1'b1;
      // SHA-224 truncates to seven words
      if (mode || (address[2:0] != 3'd7)) begin
        rdata = digest_reg[address[2:0]];
      end
    end else begin
      case (address)
        sha256_pkg::addr_name0: begin
          rdata     = sha256_pkg::name0_value;
          read_only = 1'b1;
        end
        sha256_pkg::addr_name1: begin
          rdata     = sha256_pkg::name1_value;
          read_only = 1'b1;
        end
        sha256_pkg::addr_version: begin
          rdata     = sha256_pkg::version_value;
          read_only = 1'b1;
        end
        sha256_pkg::addr_ctrl:     rdata[sha256_pkg::ctrl_mode_bit] = mode;
        sha256_pkg::addr_status: begin
          rdata[sha256_pkg::status_ready_bit] = core_ready;
          rdata[sha256_pkg::status_valid_bit] = core_digest_valid;
          read_only = 1'b1;
        end
        sha256_pkg::addr_intr_sts: rdata[1:0] = intr_sts;
        sha256_pkg::addr_intr_en:  rdata[1:0] = intr_en;
        default:                   mapped = 1'b0;
      endcase
    end
  end

  assign read_data = cs ? rdata : '0;
  assign err       = cs && (!mapped || (we && read_only));

  // --------------------------------------
  // Control, status and interrupts
  // --------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_cmd <= 1'b0;
      next_cmd <= 1'b0;
      zeroize  <= 1'b0;
      mode     <= 1'b0;
      valid_d  <= 1'b0;
      intr_sts <= '0;
      intr_en  <= '0;
    end else begin
      // Command bits are self-clearing, mode holds
      init_cmd <= wr && (address == sha256_pkg::addr_ctrl) &&
                  write_data[sha256_pkg::ctrl_init_bit];
      next_cmd <= wr && (address == sha256_pkg::addr_ctrl) &&
                  write_data[sha256_pkg::ctrl_next_bit];
      zeroize  <= wr && (address == sha256_pkg::addr_ctrl) &&
                  write_data[sha256_pkg::ctrl_zeroize_bit];
      if (wr && (address == sha256_pkg::addr_ctrl)) begin
        mode <= write_data[sha256_pkg::ctrl_mode_bit];
      end
      valid_d <= core_digest_valid;
      if (wr && (address == sha256_pkg::addr_intr_en)) begin
        intr_en <= write_data[1:0];
      end
      // New events win over a write-one-to-clear in the same cycle
      intr_sts[sha256_pkg::intr_notif_bit] <= digest_rise ||
        (intr_sts[sha256_pkg::intr_notif_bit] && !(wr &&
         (address == sha256_pkg::addr_intr_sts) && write_data[sha256_pkg::intr_notif_bit]));
      intr_sts[sha256_pkg::intr_error_bit] <= err ||
        (intr_sts[sha256_pkg::intr_error_bit] && !(wr &&
         (address == sha256_pkg::addr_intr_sts) && write_data[sha256_pkg::intr_error_bit]));
    end
  end

  assign notif_intr = intr_sts[sha256_pkg::intr_notif_bit] && intr_en[sha256_pkg::intr_notif_bit];
  assign error_intr = intr_sts[sha256_pkg::intr_error_bit] && intr_en[sha256_pkg::intr_error_bit];

  // Block words and the digest snapshot taken when valid rises
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      block_mem  <= '0;
      digest_reg <= '0;
    end else if (zeroize) begin
      block_mem  <= '0;
      digest_reg <= '0;
    end else begin
      if (wr && blk_hit) begin
        block_mem[address[3:0]] <= write_data;
      end
      if (digest_rise) begin
        digest_reg <= core_digest;
      end
    end
  end

  // Host must not start and continue a hash with one CTRL write
  a_one_cmd: assert property (@(posedge clk) disable iff (!reset_n)
    !(init_cmd && next_cmd));

endmodule

`default_nettype wire

//--- source/sha256_core.sv
// --------------------------------------
// SHA-256 compression engine
// One round per cycle over 64 cycles,
// then one cycle adding into H
// Init selects the SHA-224 or SHA-256 IV
// --------------------------------------
`default_nettype none

module sha256_core (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         zeroize,
  input  logic         init_cmd,
  input  logic         next_cmd,
  input  logic         mode,
  input  logic [511:0] block_msg,
  output logic         ready,
  output logic [255:0] digest,
  output logic         digest_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_rounds,
    st_final
  } state_t;

  state_t           state;
  logic [5:0]       round_ctr;
  logic [7:0][31:0] h_state;
  logic [7:0][31:0] h_init;
  logic [7:0][31:0] h_start;
  logic [31:0]      a, b, c, d, e, f, g, h;
  logic [31:0]      w;
  logic [31:0]      k;
  logic             start;
  logic             advance;

  // Round datapath
  logic [31:0] big_s0;
  logic [31:0] big_s1;
  logic [31:0] ch;
  logic [31:0] maj;
  logic [31:0] t1;
  logic [31:0] t2;

  // --------------------------------------
  // Command acceptance
  // --------------------------------------
  // Commands only count while idle
  assign start   = (init_cmd || next_cmd) && ready;
  assign advance = (state == st_rounds);
  assign ready   = (state == st_idle);
  assign digest  = h_state;

  assign h_init  = mode ? sha256_pkg::h0_sha256 : sha256_pkg::h0_sha224;
  // Init seeds from the IV, next chains from the current H
  assign h_start = init_cmd ? h_init : h_state;

  sha256_w_sched i_w_sched (
    .clk       (clk),
    .reset_n   (reset_n),
    .zeroize   (zeroize),
    .load      (start),
    .advance   (advance),
    .block_msg (block_msg),
    .w         (w)
  );

  sha256_k_rom i_k_rom (
    .round (round_ctr),
    .k     (k)
  );

  // --------------------------------------
  // Round function
  // --------------------------------------
  assign big_s0 = sha256_pkg::rotr(a, 2) ^ sha256_pkg::rotr(a, 13) ^ sha256_pkg::rotr(a, 22);
  assign big_s1 = sha256_pkg::rotr(e, 6) ^ sha256_pkg::rotr(e, 11) ^ sha256_pkg::rotr(e, 25);
  assign ch     = (e & f) ^ (~e & g);
  assign maj    = (a & b) ^ (a & c) ^ (b & c);
  assign t1     = h + big_s1 + ch + k + w;
  assign t2     = big_s0 + maj;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state        <= st_idle;
      round_ctr    <= '0;
      digest_valid <= 1'b0;
      h_state      <= '0;
      {a, b, c, d, e, f, g, h} <= '0;
    end else if (zeroize) begin
      // Wipe all hash material, back to idle
      state        <= st_idle;
      round_ctr    <= '0;
      digest_valid <= 1'b0;
      h_state      <= '0;
      {a, b, c, d, e, f, g, h} <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            if (init_cmd) begin
              h_state <= h_init;
            end
            {a, b, c, d, e, f, g, h} <= h_start;
            round_ctr    <= '0;
            digest_valid <= 1'b0;
            state        <= st_rounds;
          end
        end
        st_rounds: begin
          a <= t1 + t2;
          b <= a;
          c <= b;
          d <= c;
          e <= d + t1;
          f <= e;
          g <= f;
          h <= g;
          round_ctr <= round_ctr + 6'd1;
          if (round_ctr == 6'(sha256_pkg::num_rounds - 1)) begin
            state <= st_final;
          end
        end
        st_final: begin
          // Feed-forward of the working variables
          h_state[7]   <= h_state[7] + a;
          h_state[6]   <= h_state[6] + b;
          h_state[5]   <= h_state[5] + c;
          h_state[4]   <= h_state[4] + d;
          h_state[3]   <= h_state[3] + e;
          h_state[2]   <= h_state[2] + f;
          h_state[1]   <= h_state[1] + g;
          h_state[0]   <= h_state[0] + h;
          digest_valid <= 1'b1;
          state        <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------
  // Checks
  // --------------------------------------
  // A run stays in rounds for exactly num_rounds cycles
  a_round_bound: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
    $fell(ready) |-> ##(sha256_pkg::num_rounds) (state == st_final));

  // A valid digest is only shown while idle, a new command drops both together
  a_ready_valid: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
    digest_valid |-> ready);

endmodule

`default_nettype wire

//--- source/sha256_w_sched.sv
// --------------------------------------
// SHA-256 message schedule
// Holds a 16-word sliding window and
// presents one W word per round
// --------------------------------------
`default_nettype none

module sha256_w_sched (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         zeroize,
  input  logic         load,
  input  logic         advance,
  input  logic [511:0] block_msg,
  output logic [31:0]  w
);

  // Window element 0 is W[t] for the current round
  logic [0:15][31:0] w_win;
  logic [31:0]       sig0;
  logic [31:0]       sig1;
  logic [31:0]       w_new;

  // Small sigma functions on the t-15 and t-2 taps of the new word
  assign sig0 = sha256_pkg::rotr(w_win[1], 7) ^ sha256_pkg::rotr(w_win[1], 18) ^
                (w_win[1] >> 3);
  assign sig1 = sha256_pkg::rotr(w_win[14], 17) ^ sha256_pkg::rotr(w_win[14], 19) ^
                (w_win[14] >> 10);

  // W[t+16] from taps t-2, t-7, t-15 and t-16 relative to the new word
  assign w_new = sig1 + w_win[9] + sig0 + w_win[0];

  // First 16 rounds see the block words, later ones the expanded words
  assign w = w_win[0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      w_win <= '0;
    end else if (zeroize) begin
      w_win <= '0;
    end else if (load) begin
      // Word 0 of the block sits in the top bits of block_msg
      w_win <= block_msg;
    end else if (advance) begin
      w_win <= {w_win[1:15], w_new};
    end
  end

endmodule

`default_nettype wire

//--- source/sha256_k_rom.sv
// --------------------------------------
// SHA-256 round constant table
// Returns K for the round index
// --------------------------------------
`default_nettype none

module sha256_k_rom (
  input  logic [5:0]  round,
  output logic [31:0] k
);

  // First 32 bits of the fractional parts of the cube roots of the first 64 primes
  localparam logic [31:0] k_table [0:63] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Pure lookup, no state
  assign k = k_table[round];

endmodule

`default_nettype wire

//--- source/sha256_pkg.sv
// --------------------------------------
// SHA-256 accelerator shared definitions
// Register map, bus widths, control bits
// and the initial hash values of both modes
// --------------------------------------
`default_nettype none

package sha256_pkg;

  // Host bus and block geometry
  localparam int addr_width   = 8;
  localparam int data_width   = 32;
  localparam int block_words  = 16;
  localparam int digest_words = 8;
  localparam int num_rounds   = 64;

  // Word addresses of the register map
  localparam logic [addr_width-1:0] addr_name0       = 8'h00;
  localparam logic [addr_width-1:0] addr_name1       = 8'h01;
  localparam logic [addr_width-1:0] addr_version     = 8'h02;
  localparam logic [addr_width-1:0] addr_ctrl        = 8'h04;
  localparam logic [addr_width-1:0] addr_status      = 8'h05;
  localparam logic [addr_width-1:0] addr_intr_sts    = 8'h06;
  localparam logic [addr_width-1:0] addr_intr_en     = 8'h07;
  localparam logic [addr_width-1:0] addr_block_base  = 8'h10;
  localparam logic [addr_width-1:0] addr_digest_base = 8'h20;

  // CTRL fields, mode 1 selects SHA-256
  localparam int ctrl_init_bit    = 0;
  localparam int ctrl_next_bit    = 1;
  localparam int ctrl_mode_bit    = 2;
  localparam int ctrl_zeroize_bit = 3;

  // STATUS and interrupt fields
  localparam int status_ready_bit = 0;
  localparam int status_valid_bit = 1;
  localparam int intr_notif_bit   = 0;
  localparam int intr_error_bit   = 1;

  // Identity, ASCII "sha2" and "-256"
  localparam logic [data_width-1:0] name0_value   = 32'h7368_6132;
  localparam logic [data_width-1:0] name1_value   = 32'h2d32_3536;
  localparam logic [data_width-1:0] version_value = 32'h0000_0100;

  // Initial hash values, element 7 holds H0
  localparam logic [7:0][31:0] h0_sha224 = {
    32'hc105_9ed8, 32'h367c_d507, 32'h3070_dd17, 32'hf70e_5939,
    32'hffc0_0b31, 32'h6858_1511, 32'h64f9_8fa7, 32'hbefa_4fa4
  };
  localparam logic [7:0][31:0] h0_sha256 = {
    32'h6a09_e667, 32'hbb67_ae85, 32'h3c6e_f372, 32'ha54f_f53a,
    32'h510e_527f, 32'h9b05_688c, 32'h1f83_d9ab, 32'h5be0_cd19
  };

  // Rotate right, shared by the round logic and the schedule
  function automatic logic [31:0] rotr(input logic [31:0] x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

endpackage

`default_nettype wire
